// File: build.f
common/soc_pkg.sv
common/lite_pkg.sv
common/mem_req_if.sv
rtl/lite_slice.sv
rtl/soc_bus.sv
l2/l2_mem.sv
periph/periph_dwc.sv
periph/cluster_ctrl.sv
rtl/pulp_soc.sv
sim/tb_pulp_soc.sv

// File: Makefile
# Verilator build and run of the pulp_soc testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_pulp_soc -f build.f -Mdir obj_dir
	./obj_dir/Vtb_pulp_soc | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_pulp_soc.sv
// Self-checking testbench for pulp_soc with four clusters and 4 KiB of L2.
// Concurrent assertions compare each host response with a reference model.
// L2 reads only touch words that were written first; N_CL stays at most 8.
`timescale 1ns/10ps
`default_nettype none

module tb_pulp_soc;
  import soc_pkg::*;
  import lite_pkg::*;

  localparam int unsigned N_CL    = 4;
  localparam int unsigned L2_SIZE = 4096;
  localparam int unsigned N_WORDS = 32;
  localparam int unsigned TIMEOUT = 200;

  logic              clk_i;
  logic              rst_n_i;
  logic              aw_valid_i;
  logic              aw_ready_o;
  logic [31:0]       aw_addr_i;
  logic              w_valid_i;
  logic              w_ready_o;
  logic [63:0]       w_data_i;
  logic [7:0]        w_strb_i;
  logic              b_valid_o;
  logic              b_ready_i = 1'b0;
  resp_e             b_resp_o;
  logic              ar_valid_i;
  logic              ar_ready_o;
  logic [31:0]       ar_addr_i;
  logic              r_valid_o;
  logic              r_ready_i = 1'b0;
  logic [63:0]       r_data_o;
  resp_e             r_resp_o;
  logic [N_CL-1:0]   cl_fetch_en_o;
  logic [N_CL-1:0]   cl_eoc_i;
  logic [N_CL-1:0]   cl_busy_i;

  // sparse L2 reference model keyed by byte address
  logic [63:0]       l2_model [logic [31:0]];
  logic [N_CL-1:0]   exp_fe;
  logic [N_CL-1:0]   exp_eoc;
  logic              rd_prio;

  // expected responses and service order
  resp_e             exp_bresp;
  resp_e             exp_rresp;
  logic [63:0]       exp_rdata;
  logic              pair_on;
  logic              wr_first;
  int unsigned       b_cnt;
  int unsigned       r_cnt;
  int unsigned       b_goal;
  int unsigned       r_goal;
  logic              rand_ready;
  logic              chk_reset;
  logic              chk_fe;

  pulp_soc #(
    .N_CLUSTERS (N_CL),
    .L2_BYTES   (L2_SIZE)
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // host back-pressure on b and r
  always @(posedge clk_i) begin
    b_ready_i <= rand_ready ? 1'($urandom) : 1'b1;
    r_ready_i <= rand_ready ? 1'($urandom) : 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_cnt <= 0;
      r_cnt <= 0;
    end else begin
      if (b_valid_o && b_ready_i) begin
        b_cnt <= b_cnt + 1;
      end
      if (r_valid_o && r_ready_i) begin
        r_cnt <= r_cnt + 1;
      end
    end
  end

  task automatic flag_mismatch(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
    $display("mismatch %s: expected 0x%h, got 0x%h", name, exp_v, got_v);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("error: %s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  a_reset_idle: assert property (@(posedge clk_i) chk_reset |->
      (!b_valid_o && !r_valid_o && aw_ready_o && w_ready_o && ar_ready_o))
    else abort_run("handshake outputs are not idle after reset");

  a_fetch_en: assert property (@(posedge clk_i) (chk_reset || chk_fe) |->
      (cl_fetch_en_o == exp_fe))
    else flag_mismatch("cl_fetch_en_o", 64'($sampled(exp_fe)), 64'($sampled(cl_fetch_en_o)));

  a_bresp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (b_valid_o && b_ready_i) |-> (b_resp_o == exp_bresp))
    else flag_mismatch("b_resp_o", 64'($sampled(exp_bresp)), 64'($sampled(b_resp_o)));

  a_rresp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (r_valid_o && r_ready_i) |-> (r_resp_o == exp_rresp))
    else flag_mismatch("r_resp_o", 64'($sampled(exp_rresp)), 64'($sampled(r_resp_o)));

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (r_valid_o && r_ready_i) |-> (r_data_o == exp_rdata))
    else flag_mismatch("r_data_o", $sampled(exp_rdata), $sampled(r_data_o));

  // in a pair the first response must come from the first grant
  a_order_b: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (b_valid_o && b_ready_i && pair_on) |-> ((r_cnt == r_goal) != wr_first))
    else abort_run("write response came out of round-robin order");

  a_order_r: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (r_valid_o && r_ready_i && pair_on) |-> ((b_cnt == b_goal) == wr_first))
    else abort_run("read response came out of round-robin order");

  function automatic logic [63:0] byte_merge(input logic [63:0] old_w,
                                             input logic [63:0] new_w,
                                             input logic [7:0] strb);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic in_l2(input logic [31:0] addr);
    return (addr >= L2_BASE) && (addr < L2_BASE + L2_SIZE);
  endfunction

  function automatic logic in_periph(input logic [31:0] addr);
    return (addr >= PERIPH_BASE) && (addr < PERIPH_BASE + PERIPH_SIZE);
  endfunction

  function automatic resp_e map_resp(input logic [31:0] addr);
    if (in_l2(addr) || in_periph(addr)) begin
      return OKAY;
    end else begin
      return DECERR;
    end
  endfunction

  function automatic void apply_write(input logic [31:0] addr, input logic [63:0] data,
                                      input logic [7:0] strb);
    if (in_l2(addr)) begin
      l2_model[addr] = byte_merge(l2_model[addr], data, strb);
    end else if (in_periph(addr) && (addr[11:0] == 12'h000)) begin
      // low lane holds fetch enable and high lane clears eoc bits
      if (strb[0]) begin
        exp_fe = data[N_CL-1:0];
      end
      if (strb[4]) begin
        exp_eoc = (exp_eoc & ~data[32 +: N_CL]) | cl_eoc_i;
      end
    end
  endfunction

  function automatic logic [63:0] predict_read(input logic [31:0] addr);
    logic [63:0] data;
    data = '0;
    if (in_l2(addr)) begin
      data = l2_model[addr];
    end else if (in_periph(addr)) begin
      case (addr[11:0])
        12'h000: data = {32'(exp_eoc), 32'(exp_fe)};
        12'h008: data = {32'(N_CL), 32'(cl_busy_i)};
        default: data = '0;
      endcase
    end
    return data;
  endfunction

  // word addresses spread over the whole L2
  function automatic logic [31:0] l2_word(input int unsigned idx);
    return L2_BASE + 32'(idx) * 32'd128;
  endfunction

  function automatic logic [31:0] pick_addr();
    if ($urandom_range(1) == 0) begin
      return l2_word($urandom_range(N_WORDS - 1));
    end else begin
      return PERIPH_BASE + 32'($urandom_range(2)) * 32'd8;
    end
  endfunction

  // one write, one read, or both together on the same edge
  task automatic do_access(input logic do_wr, input logic [31:0] waddr,
                           input logic [63:0] wdata, input logic [7:0] wstrb,
                           input logic do_rd, input logic [31:0] raddr);
    int unsigned t;
    logic        aw_hs;
    logic        w_hs;
    logic        ar_hs;
    logic        rd_early;
    b_goal   = b_cnt + 32'(do_wr);
    r_goal   = r_cnt + 32'(do_rd);
    rd_early = do_rd && (!do_wr || rd_prio);
    pair_on  = do_wr && do_rd;
    wr_first = !rd_early;
    if (rd_early) begin
      exp_rdata = predict_read(raddr);
      exp_rresp = map_resp(raddr);
    end
    if (do_wr) begin
      apply_write(waddr, wdata, wstrb);
      exp_bresp = map_resp(waddr);
    end
    if (do_rd && !rd_early) begin
      exp_rdata = predict_read(raddr);
      exp_rresp = map_resp(raddr);
    end
    // priority goes to the kind not granted last
    rd_prio = do_wr && (!do_rd || rd_early);

    @(posedge clk_i);
    aw_valid_i <= do_wr;
    aw_addr_i  <= waddr;
    w_valid_i  <= do_wr;
    w_data_i   <= wdata;
    w_strb_i   <= wstrb;
    ar_valid_i <= do_rd;
    ar_addr_i  <= raddr;
    t = 0;
    do begin
      @(negedge clk_i);
      aw_hs = aw_valid_i & aw_ready_o;
      w_hs  = w_valid_i & w_ready_o;
      ar_hs = ar_valid_i & ar_ready_o;
      @(posedge clk_i);
      if (aw_hs) begin
        aw_valid_i <= 1'b0;
      end
      if (w_hs) begin
        w_valid_i <= 1'b0;
      end
      if (ar_hs) begin
        ar_valid_i <= 1'b0;
      end
      t++;
      if (t > TIMEOUT) begin
        abort_run("host request was never accepted");
      end
    end while ((aw_valid_i && !aw_hs) || (w_valid_i && !w_hs) || (ar_valid_i && !ar_hs));

    t = 0;
    while ((b_cnt != b_goal) || (r_cnt != r_goal)) begin
      @(negedge clk_i);
      t++;
      if (t > TIMEOUT) begin
        abort_run("no response arrived from the bus");
      end
    end
  endtask

  task automatic check_fetch_en();
    @(posedge clk_i);
    chk_fe <= 1'b1;
    @(posedge clk_i);
    chk_fe <= 1'b0;
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] raddr;
    int unsigned kind;
    void'($urandom(32'he9ae));
    rst_n_i    = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    cl_eoc_i   = '0;
    cl_busy_i  = '0;
    exp_fe     = '0;
    exp_eoc    = '0;
    rd_prio    = 1'b0;
    exp_bresp  = OKAY;
    exp_rresp  = OKAY;
    exp_rdata  = '0;
    pair_on    = 1'b0;
    wr_first   = 1'b0;
    b_goal     = 0;
    r_goal     = 0;
    rand_ready = 1'b0;
    chk_reset  = 1'b0;
    chk_fe     = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i   <= 1'b1;
    chk_reset <= 1'b1;
    @(posedge clk_i);
    chk_reset <= 1'b0;

    // fill the L2 words in use before strobed writes with read-back
    for (int i = 0; i < N_WORDS; i++) begin
      do_access(1'b1, l2_word(i), {$urandom, $urandom}, 8'hFF, 1'b0, '0);
    end
    for (int i = 0; i < 60; i++) begin
      addr = l2_word($urandom_range(N_WORDS - 1));
      do_access(1'b1, addr, {$urandom, $urandom}, 8'($urandom), 1'b0, '0);
      do_access(1'b0, '0, '0, '0, 1'b1, addr);
    end

    // mixed traffic to both targets under back-pressure
    @(posedge clk_i);
    cl_busy_i  <= N_CL'($urandom);
    rand_ready <= 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < 120; i++) begin
      kind  = $urandom_range(3);
      addr  = pick_addr();
      raddr = ($urandom_range(1) == 0) ? addr : pick_addr();
      case (kind)
        0:       do_access(1'b1, addr, {$urandom, $urandom}, 8'($urandom), 1'b0, '0);
        1:       do_access(1'b0, '0, '0, '0, 1'b1, raddr);
        default: do_access(1'b1, addr, {$urandom, $urandom}, 8'($urandom), 1'b1, raddr);
      endcase
    end
    rand_ready <= 1'b0;
    check_fetch_en();

    // fetch enable, busy and info
    do_access(1'b1, PERIPH_BASE, 64'hFFFF_FFFF_FFFF_FFF5, 8'h0F, 1'b0, '0);
    check_fetch_en();
    do_access(1'b0, '0, '0, '0, 1'b1, PERIPH_BASE);
    do_access(1'b1, PERIPH_BASE, 64'h0000_0000_0000_000A, 8'h01, 1'b0, '0);
    check_fetch_en();
    do_access(1'b0, '0, '0, '0, 1'b1, PERIPH_BASE + 32'h8);

    // sticky eoc where a pulse still present beats the clear
    @(posedge clk_i);
    cl_eoc_i <= 4'b0100;
    @(posedge clk_i);
    cl_eoc_i <= 4'b0010;
    exp_eoc  = exp_eoc | 4'b0100;
    @(posedge clk_i);
    exp_eoc  = exp_eoc | 4'b0010;
    do_access(1'b0, '0, '0, '0, 1'b1, PERIPH_BASE);
    do_access(1'b1, PERIPH_BASE, 64'h0000_0006_0000_0000, 8'hF0, 1'b1, PERIPH_BASE);
    @(posedge clk_i);
    cl_eoc_i <= '0;
    @(posedge clk_i);
    do_access(1'b1, PERIPH_BASE, 64'h0000_0002_0000_0000, 8'hF0, 1'b1, PERIPH_BASE);

    // unmapped addresses followed by a read-back of the model state
    do_access(1'b1, 32'h0000_0040, {$urandom, $urandom}, 8'hFF, 1'b1, 32'h0000_0040);
    do_access(1'b1, L2_BASE + L2_SIZE, {$urandom, $urandom}, 8'hFF, 1'b0, '0);
    do_access(1'b1, PERIPH_BASE + PERIPH_SIZE, 64'hF, 8'hFF, 1'b0, '0);
    do_access(1'b0, '0, '0, '0, 1'b1, L2_BASE + L2_SIZE);
    do_access(1'b0, '0, '0, '0, 1'b1, l2_word(0));
    do_access(1'b0, '0, '0, '0, 1'b1, PERIPH_BASE);
    check_fetch_en();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/pulp_soc.sv
// SoC top, AXI-Lite host slave port to L2 and cluster control.
// Clusters are external and reached only through the cl_* ports.
// L2_BYTES must be a power of two; N_CLUSTERS ranges from 1 to 32.
`timescale 1ns/10ps
`default_nettype none

module pulp_soc #(
  parameter int unsigned N_CLUSTERS = 4,
  parameter int unsigned L2_BYTES   = 4096
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // host write address
  input  logic                          aw_valid_i,
  output logic                          aw_ready_o,
  input  logic [soc_pkg::ADDR_W-1:0]    aw_addr_i,
  // host write data
  input  logic                          w_valid_i,
  output logic                          w_ready_o,
  input  logic [soc_pkg::HOST_DW-1:0]   w_data_i,
  input  logic [soc_pkg::HOST_DW/8-1:0] w_strb_i,
  // host write response
  output logic                          b_valid_o,
  input  logic                          b_ready_i,
  output lite_pkg::resp_e               b_resp_o,
  // host read address
  input  logic                          ar_valid_i,
  output logic                          ar_ready_o,
  input  logic [soc_pkg::ADDR_W-1:0]    ar_addr_i,
  // host read data
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output logic [soc_pkg::HOST_DW-1:0]   r_data_o,
  output lite_pkg::resp_e               r_resp_o,
  // cluster control
  output logic [N_CLUSTERS-1:0]         cl_fetch_en_o,
  input  logic [N_CLUSTERS-1:0]         cl_eoc_i,
  input  logic [N_CLUSTERS-1:0]         cl_busy_i
);
  import soc_pkg::*;
  import lite_pkg::*;

  addr_t   aw_addr;
  addr_t   ar_addr;
  w_chan_t w_in;
  w_chan_t w_chan;
  logic    aw_valid;
  logic    aw_ready;
  logic    w_valid;
  logic    w_ready;
  logic    ar_valid;
  logic    ar_ready;

  mem_req_if #(.DW(HOST_DW))   l2_bus ();
  mem_req_if #(.DW(HOST_DW))   periph_bus ();
  mem_req_if #(.DW(PERIPH_DW)) reg_bus ();

  assign w_in = '{data: w_data_i, strb: w_strb_i};

  // request channel slices
  lite_slice #(.data_t(addr_t)) i_aw_slice (
    .clk_i,
    .rst_n_i,
    .valid_i (aw_valid_i),
    .ready_o (aw_ready_o),
    .data_i  (aw_addr_i),
    .valid_o (aw_valid),
    .ready_i (aw_ready),
    .data_o  (aw_addr)
  );

  lite_slice #(.data_t(w_chan_t)) i_w_slice (
    .clk_i,
    .rst_n_i,
    .valid_i (w_valid_i),
    .ready_o (w_ready_o),
    .data_i  (w_in),
    .valid_o (w_valid),
    .ready_i (w_ready),
    .data_o  (w_chan)
  );

  lite_slice #(.data_t(addr_t)) i_ar_slice (
    .clk_i,
    .rst_n_i,
    .valid_i (ar_valid_i),
    .ready_o (ar_ready_o),
    .data_i  (ar_addr_i),
    .valid_o (ar_valid),
    .ready_i (ar_ready),
    .data_o  (ar_addr)
  );

  soc_bus #(.L2_BYTES(L2_BYTES)) i_soc_bus (
    .clk_i,
    .rst_n_i,
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_addr_i  (aw_addr),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .w_data_i   (w_chan),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .b_valid_o,
    .b_ready_i,
    .b_resp_o,
    .r_valid_o,
    .r_ready_i,
    .r_data_o,
    .r_resp_o,
    .l2         (l2_bus),
    .periph     (periph_bus)
  );

  l2_mem #(.L2_BYTES(L2_BYTES)) i_l2_mem (
    .clk_i,
    .rst_n_i,
    .bus (l2_bus)
  );

  periph_dwc i_dwc_periph (
    .clk_i,
    .rst_n_i,
    .slv (periph_bus),
    .mst (reg_bus)
  );

  cluster_ctrl #(.N_CLUSTERS(N_CLUSTERS)) i_cluster_ctrl (
    .clk_i,
    .rst_n_i,
    .bus (reg_bus),
    .cl_fetch_en_o,
    .cl_eoc_i,
    .cl_busy_i
  );

endmodule

`default_nettype wire

// File: periph/cluster_ctrl.sv
// Cluster control registers, 32-bit, one cycle read latency.
// EOC bits are sticky and cleared by writing 1; a pulse still present wins.
// Bits at or above N_CLUSTERS and unknown offsets read as zero.
`timescale 1ns/10ps
`default_nettype none

module cluster_ctrl #(
  parameter int unsigned N_CLUSTERS = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  mem_req_if.sub                bus,
  output logic [N_CLUSTERS-1:0] cl_fetch_en_o,
  input  logic [N_CLUSTERS-1:0] cl_eoc_i,
  input  logic [N_CLUSTERS-1:0] cl_busy_i
);
  import soc_pkg::*;

  logic [N_CLUSTERS-1:0]   fetch_en_q;
  logic [N_CLUSTERS-1:0]   eoc_q;
  logic [N_CLUSTERS-1:0]   wr_bits;
  logic [N_CLUSTERS-1:0]   eoc_clr;
  logic [PERIPH_DW-1:0]    wmask;
  logic [PERIPH_DW-1:0]    rdata_d;
  logic [PERIPH_DW-1:0]    rdata_q;
  logic                    rvalid_q;
  logic [PERIPH_OFF_W-1:0] offs;
  logic                    wr_en;

  if ((N_CLUSTERS == 0) || (N_CLUSTERS > MAX_CLUSTERS)) begin : gen_cfg_check
    $error("N_CLUSTERS must be between 1 and MAX_CLUSTERS");
  end

  assign offs  = bus.addr[PERIPH_OFF_W-1:0];
  assign wr_en = bus.valid & bus.we;

  // byte strobes widened to a bit mask
  always_comb begin
    for (int b = 0; b < PERIPH_DW / 8; b++) begin
      wmask[b*8 +: 8] = {8{bus.strb[b]}};
    end
  end

  assign wr_bits = bus.wdata[N_CLUSTERS-1:0] & wmask[N_CLUSTERS-1:0];
  assign eoc_clr = (wr_en && (offs == REG_EOC)) ? wr_bits : '0;

  always_comb begin
    case (offs)
      REG_FETCH_EN: rdata_d = PERIPH_DW'(fetch_en_q);
      REG_EOC:      rdata_d = PERIPH_DW'(eoc_q);
      REG_BUSY:     rdata_d = PERIPH_DW'(cl_busy_i);
      REG_INFO:     rdata_d = PERIPH_DW'(N_CLUSTERS);
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fetch_en_q <= '0;
      eoc_q      <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= bus.valid;
      if (wr_en && (offs == REG_FETCH_EN)) begin
        fetch_en_q <= (fetch_en_q & ~wmask[N_CLUSTERS-1:0]) | wr_bits;
      end
      eoc_q <= cl_eoc_i | (eoc_q & ~eoc_clr);
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.valid && !bus.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rvalid    = rvalid_q;
  assign bus.rdata     = rdata_q;
  assign bus.err       = 1'b0;
  assign cl_fetch_en_o = fetch_en_q;

endmodule

`default_nettype wire

// File: periph/periph_dwc.sv
// Splits a 64-bit access into 32-bit lane accesses at addr and addr+4.
// Reads fetch both lanes; writes skip a lane with no strobes set.
// Assumes 8-byte aligned addresses and a one-cycle register block.
// Answers 2 cycles after valid for one lane, 3 for two.
`timescale 1ns/10ps
`default_nettype none

module periph_dwc (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_req_if.sub slv,
  mem_req_if.mgr mst
);
  import soc_pkg::*;

  localparam int unsigned LB = PERIPH_DW / 8;

  logic                 issue_q;
  logic                 more_q;
  logic                 pend_q;
  logic                 lane_q;
  logic                 err_q;
  logic                 we_q;
  logic [ADDR_W-1:0]    addr_q;
  logic [HOST_DW-1:0]   wdata_q;
  logic [HOST_DW/8-1:0] strb_q;
  logic [PERIPH_DW-1:0] lo_q;
  logic                 first_hi;
  logic                 need_hi;
  logic                 lane_now;

  // write touching only the high word starts there
  assign first_hi = slv.we & ~|slv.strb[LB-1:0] & |slv.strb[2*LB-1:LB];
  assign need_hi  = ~slv.we | |slv.strb[2*LB-1:LB];

  // high lane goes out in the cycle the low lane answers
  assign lane_now = lane_q | (mst.rvalid & more_q);

  assign mst.valid = issue_q | (mst.rvalid & more_q);
  assign mst.we    = we_q;
  assign mst.addr  = lane_now ? (addr_q + ADDR_W'(LB)) : addr_q;
  assign mst.wdata = lane_now ? wdata_q[HOST_DW-1:PERIPH_DW] : wdata_q[PERIPH_DW-1:0];
  assign mst.strb  = lane_now ? strb_q[2*LB-1:LB] : strb_q[LB-1:0];

  assign slv.rvalid = mst.rvalid & ~more_q;
  assign slv.rdata  = {mst.rdata, lo_q};
  assign slv.err    = mst.err | err_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      issue_q <= 1'b0;
      more_q  <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      issue_q <= slv.valid;
      if (slv.valid) begin
        more_q <= ~first_hi & need_hi;
      end else if (mst.rvalid) begin
        more_q <= 1'b0;
      end
      if (mst.valid) begin
        pend_q <= 1'b1;
      end else if (mst.rvalid) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv.valid) begin
      we_q    <= slv.we;
      addr_q  <= {slv.addr[ADDR_W-1:3], 3'b000};
      wdata_q <= slv.wdata;
      strb_q  <= slv.strb;
      lane_q  <= first_hi;
      err_q   <= 1'b0;
    end else if (mst.rvalid && more_q) begin
      // low lane done, keep its data for the merge
      lo_q   <= mst.rdata;
      err_q  <= mst.err;
      lane_q <= 1'b1;
    end
  end

  a_rvalid_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst.rvalid |-> pend_q);

endmodule

`default_nettype wire

// File: l2/l2_mem.sv
// Byte-strobed 64-bit L2 memory, response one cycle after valid.
// The address wraps modulo L2_BYTES and must be a power of two.
// Contents are not cleared by reset. Never reports an error.
`timescale 1ns/10ps
`default_nettype none

module l2_mem #(
  parameter int unsigned L2_BYTES = 4096
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_req_if.sub bus
);
  import soc_pkg::*;

  localparam int unsigned NB    = HOST_DW / 8;
  localparam int unsigned WORDS = L2_BYTES / NB;
  localparam int unsigned OFF_W = $clog2(NB);
  localparam int unsigned IDX_W = $clog2(WORDS);

  logic [HOST_DW-1:0] mem_q [WORDS];
  logic [HOST_DW-1:0] rdata_q;
  logic               rvalid_q;
  logic [IDX_W-1:0]   idx;

  // word index, byte offset bits dropped
  assign idx = bus.addr[OFF_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (bus.valid && bus.we) begin
      for (int b = 0; b < NB; b++) begin
        if (bus.strb[b]) begin
          mem_q[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
    if (bus.valid && !bus.we) begin
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.valid;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

`default_nettype wire

// File: rtl/soc_bus.sv
// Host bus control, one transaction at a time.
// Reads and writes are served round robin. Addresses outside L2 and the
// cluster control block are answered here with DECERR; a read then gives 0.
// A stalled b or r response stalls the whole bus.
`timescale 1ns/10ps
`default_nettype none

module soc_bus #(
  parameter int unsigned L2_BYTES = 4096
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  lite_pkg::addr_t             aw_addr_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  lite_pkg::w_chan_t           w_data_i,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  lite_pkg::addr_t             ar_addr_i,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output lite_pkg::resp_e             b_resp_o,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output logic [soc_pkg::HOST_DW-1:0] r_data_o,
  output lite_pkg::resp_e             r_resp_o,
  mem_req_if.mgr                      l2,
  mem_req_if.mgr                      periph
);
  import soc_pkg::*;
  import lite_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESP} state_e;
  typedef enum logic [1:0] {TGT_L2, TGT_PERIPH, TGT_NONE} tgt_e;

  state_e               state_q;
  tgt_e                 tgt_d;
  tgt_e                 tgt_q;
  logic                 rd_prio_q;
  logic                 wr_req;
  logic                 rd_req;
  logic                 grant_wr;
  logic                 grant_rd;
  addr_t                sel_addr;
  addr_t                addr_q;
  logic                 we_q;
  logic [HOST_DW-1:0]   wdata_q;
  logic [HOST_DW/8-1:0] strb_q;
  logic [HOST_DW-1:0]   rdata_q;
  resp_e                resp_q;
  logic                 l2_valid_q;
  logic                 periph_valid_q;
  logic                 tgt_rvalid;
  logic [HOST_DW-1:0]   tgt_rdata;
  logic                 tgt_err;
  logic                 req_open_q;

  // a write needs both address and data before it can start
  assign wr_req = aw_valid_i & w_valid_i;
  assign rd_req = ar_valid_i;

  // on a tie the kind not granted last wins
  assign grant_rd = (state_q == ST_IDLE) & rd_req & (~wr_req | rd_prio_q);
  assign grant_wr = (state_q == ST_IDLE) & wr_req & ~grant_rd;

  assign aw_ready_o = grant_wr;
  assign w_ready_o  = grant_wr;
  assign ar_ready_o = grant_rd;
  assign sel_addr   = grant_rd ? ar_addr_i : aw_addr_i;

  // unsigned offset compare also rejects addresses below the base
  always_comb begin
    if ((sel_addr - L2_BASE) < ADDR_W'(L2_BYTES)) begin
      tgt_d = TGT_L2;
    end else if ((sel_addr - PERIPH_BASE) < ADDR_W'(PERIPH_SIZE)) begin
      tgt_d = TGT_PERIPH;
    end else begin
      tgt_d = TGT_NONE;
    end
  end

  // response of the selected target only
  assign tgt_rvalid = (tgt_q == TGT_L2) ? l2.rvalid : periph.rvalid;
  assign tgt_rdata  = (tgt_q == TGT_L2) ? l2.rdata : periph.rdata;
  assign tgt_err    = (tgt_q == TGT_L2) ? l2.err : periph.err;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q        <= ST_IDLE;
      rd_prio_q      <= 1'b0;
      l2_valid_q     <= 1'b0;
      periph_valid_q <= 1'b0;
    end else begin
      l2_valid_q     <= 1'b0;
      periph_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (grant_wr | grant_rd) begin
            rd_prio_q      <= grant_wr;
            l2_valid_q     <= (tgt_d == TGT_L2);
            periph_valid_q <= (tgt_d == TGT_PERIPH);
            state_q        <= (tgt_d == TGT_NONE) ? ST_RESP : ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (tgt_rvalid) begin
            state_q <= ST_RESP;
          end
        end
        ST_RESP: begin
          if ((we_q & b_ready_i) | (~we_q & r_ready_i)) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // transaction payload
  always_ff @(posedge clk_i) begin
    if (grant_wr | grant_rd) begin
      tgt_q   <= tgt_d;
      addr_q  <= sel_addr;
      we_q    <= grant_wr;
      wdata_q <= w_data_i.data;
      strb_q  <= w_data_i.strb;
      rdata_q <= '0;
      resp_q  <= (tgt_d == TGT_NONE) ? DECERR : OKAY;
    end else if ((state_q == ST_WAIT) && tgt_rvalid) begin
      rdata_q <= tgt_rdata;
      resp_q  <= tgt_err ? DECERR : OKAY;
    end
  end

  assign l2.valid     = l2_valid_q;
  assign l2.we        = we_q;
  assign l2.addr      = addr_q;
  assign l2.wdata     = wdata_q;
  assign l2.strb      = strb_q;
  assign periph.valid = periph_valid_q;
  assign periph.we    = we_q;
  assign periph.addr  = addr_q;
  assign periph.wdata = wdata_q;
  assign periph.strb  = strb_q;

  assign b_valid_o = (state_q == ST_RESP) & we_q;
  assign b_resp_o  = resp_q;
  assign r_valid_o = (state_q == ST_RESP) & ~we_q;
  assign r_data_o  = rdata_q;
  assign r_resp_o  = resp_q;

  // a target request that has not been answered yet
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_open_q <= 1'b0;
    end else if (l2.valid || periph.valid) begin
      req_open_q <= 1'b1;
    end else if (l2.rvalid || periph.rvalid) begin
      req_open_q <= 1'b0;
    end
  end

  // no new request while a target still owes its answer
  a_one_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (l2.valid || periph.valid) |-> !req_open_q);

  // targets only answer while their request is outstanding
  a_rvalid_from_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (l2.rvalid || periph.rvalid) |->
      ((state_q == ST_WAIT) && !(l2.rvalid && periph.rvalid) &&
       (l2.rvalid ? (tgt_q == TGT_L2) : (tgt_q == TGT_PERIPH))));

endmodule

`default_nettype wire

// File: rtl/lite_slice.sv
// Two-entry valid/ready buffer for one AXI-Lite request channel.
// Accepted data shows up at the output one cycle later. ready_o drops only
// when both entries are full, so a full-rate stream is never throttled.
`timescale 1ns/10ps
`default_nettype none

module lite_slice #(
  parameter type data_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o
);

  data_t      mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push;
  logic       pop;

  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;
  assign ready_o = (cnt_q != 2'd2);
  assign valid_o = (cnt_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // a stalled output keeps its data until the consumer takes it
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)));

endmodule

`default_nettype wire

// File: common/mem_req_if.sv
// Internal memory request bus with a single outstanding access.
// valid is a one-cycle pulse and each pulse gets exactly one rvalid pulse
// later. The manager waits for that rvalid before the next valid.
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if #(
  parameter int unsigned DW = 64
) ();

  // request, driven by the manager
  logic                       valid;
  logic                       we;
  logic [soc_pkg::ADDR_W-1:0] addr;
  logic [DW-1:0]              wdata;
  logic [DW/8-1:0]            strb;

  // response, driven by the subordinate
  logic                       rvalid;
  logic [DW-1:0]              rdata;
  logic                       err;

  modport mgr (
    output valid, we, addr, wdata, strb,
    input  rvalid, rdata, err
  );

  modport sub (
    input  valid, we, addr, wdata, strb,
    output rvalid, rdata, err
  );

endinterface

`default_nettype wire

// File: common/lite_pkg.sv
// AXI-Lite response codes and channel payloads for the host port.
// Only OKAY and DECERR are ever returned.
`default_nettype none

package lite_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } resp_e;

  // aw and ar payload
  typedef logic [soc_pkg::ADDR_W-1:0] addr_t;

  // w payload, data and byte strobes
  typedef struct packed {
    logic [soc_pkg::HOST_DW-1:0]   data;
    logic [soc_pkg::HOST_DW/8-1:0] strb;
  } w_chan_t;

endpackage

`default_nettype wire

// File: common/soc_pkg.sv
// SoC address map and bus widths.
// L2 and the cluster control block must not overlap in the address map.
`default_nettype none

package soc_pkg;

  // bus widths
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned HOST_DW   = 64;
  localparam int unsigned PERIPH_DW = 32;

  // address map
  localparam logic [ADDR_W-1:0] L2_BASE     = 32'h1C00_0000;
  localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h1A10_0000;
  localparam int unsigned       PERIPH_SIZE = 4096;

  // cluster count limit, one register bit per cluster
  localparam int unsigned MAX_CLUSTERS = 32;

  // cluster control register offsets
  localparam int unsigned             PERIPH_OFF_W = $clog2(PERIPH_SIZE);
  localparam logic [PERIPH_OFF_W-1:0] REG_FETCH_EN = 12'h000;
  localparam logic [PERIPH_OFF_W-1:0] REG_EOC      = 12'h004;
  localparam logic [PERIPH_OFF_W-1:0] REG_BUSY     = 12'h008;
  localparam logic [PERIPH_OFF_W-1:0] REG_INFO     = 12'h00C;

endpackage

`default_nettype wire
